/* Bender.yml */
package:
  name: processor

sources:
  - common/cpu_pkg.sv
  - common/fill_if.sv
  - fill/fill_fsm.sv
  - fill/fill_counter.sv
  - fill/fill_store_unit.sv
  - source/front_end.sv
  - execute/execute_stage.sv
  - source/mem_wb_unit.sv
  - source/processor.sv
  - target: test
    files:
      - verif/processor_props.sv
      - verif/processor_tb.sv

/* common/cpu_pkg.sv */
// Word-addressed core with 32-bit instructions; a fill covers at most 65535 words
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [16:0] imm_t;
    typedef logic [26:0] target_t;
    typedef logic [15:0] fill_count_t;   // Words left in a fill
    typedef logic [3:0]  fill_data_t;

    typedef enum logic [4:0] {
        op_rtype = 5'b00000,
        op_j     = 5'b00001,
        op_bne   = 5'b00010,
        op_addi  = 5'b00101,
        op_sw    = 5'b00111,
        op_lw    = 5'b01000,
        op_fill  = 5'b01001
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add = 5'b00000,
        alu_sub = 5'b00001,
        alu_and = 5'b00010,
        alu_or  = 5'b00011,
        alu_sll = 5'b00100,
        alu_sra = 5'b00101
    } alu_op_e;

    typedef enum logic [1:0] {fill_idle, fill_write, fill_release} fill_state_e;

    // --------------------
    // Instruction fields
    localparam int opcode_lsb = 27;
    localparam int rd_lsb     = 22;
    localparam int rs_lsb     = 17;
    localparam int rt_lsb     = 12;
    localparam int shamt_lsb  = 7;
    localparam int alu_op_lsb = 2;

    localparam instr_t nop_instr = '0;   // add r0, r0, r0

    localparam fill_data_t lfsr_seed     = 4'b0001;
    localparam fill_data_t lfsr_tap_mask = 4'b1100;   // x^4 + x^3 + 1

    function automatic opcode_e opcode_of(instr_t instr);
        return opcode_e'(instr[opcode_lsb +: 5]);
    endfunction

    function automatic reg_addr_t rd_of(instr_t instr);
        return instr[rd_lsb +: $bits(reg_addr_t)];
    endfunction

    function automatic reg_addr_t rs_of(instr_t instr);
        return instr[rs_lsb +: $bits(reg_addr_t)];
    endfunction

    function automatic reg_addr_t rt_of(instr_t instr);
        return instr[rt_lsb +: $bits(reg_addr_t)];
    endfunction

    // bne and sw use rd as a source, so it goes on port a
    function automatic reg_addr_t src_a_of(instr_t instr);
        return (opcode_of(instr) inside {op_bne, op_sw}) ? rd_of(instr) : rs_of(instr);
    endfunction

    function automatic reg_addr_t src_b_of(instr_t instr);
        return (opcode_of(instr) inside {op_bne, op_sw}) ? rs_of(instr) : rt_of(instr);
    endfunction

    // Writes to r0 are dropped here so bubbles never count as writers
    function automatic logic writes_reg(instr_t instr);
        return (opcode_of(instr) inside {op_rtype, op_addi, op_lw}) && (rd_of(instr) != '0);
    endfunction

    function automatic logic produces(instr_t instr, reg_addr_t src);
        return writes_reg(instr) && (rd_of(instr) == src);
    endfunction

endpackage

`default_nettype wire

/* common/fill_if.sv */
// start is a one-cycle pulse; busy stays high from the first write cycle through release
`default_nettype none

interface fill_if;

    logic                 start;
    cpu_pkg::word_t       base;
    cpu_pkg::fill_count_t length;
    logic                 busy;           // Freeze level
    logic                 release_fill;   // Last cycle of busy
    logic                 write_en;
    cpu_pkg::word_t       address;
    cpu_pkg::word_t       write_data;

    modport requester (output start, base, length, input busy, release_fill);
    modport sequencer (input start, output busy, release_fill);
    modport store     (input start, base, output write_en, address, write_data);
    modport memory    (input busy, write_en, address, write_data);

endinterface

`default_nettype wire

/* compile.f */
common/cpu_pkg.sv
common/fill_if.sv
fill/fill_fsm.sv
fill/fill_counter.sv
fill/fill_store_unit.sv
source/front_end.sv
execute/execute_stage.sv
source/mem_wb_unit.sv
source/processor.sv
verif/processor_props.sv
verif/processor_tb.sv

/* execute/execute_stage.sv */
// Branch and jump resolve here with two squashed slots; a fill holds this stage until release
`default_nettype none

module execute_stage (
    input  logic             clock,
    input  logic             reset,
    input  cpu_pkg::word_t   fd_pc,
    input  cpu_pkg::instr_t  fd_instr,
    input  cpu_pkg::word_t   reg_read_data_a,
    input  cpu_pkg::word_t   reg_read_data_b,
    input  logic             stall,
    fill_if.requester        fill,
    input  cpu_pkg::instr_t  fwd_mem_instr,
    input  cpu_pkg::word_t   fwd_mem_value,
    input  cpu_pkg::instr_t  fwd_wb_instr,
    input  cpu_pkg::word_t   fwd_wb_value,
    output cpu_pkg::instr_t  ex_instr,
    output cpu_pkg::word_t   ex_result,
    output cpu_pkg::word_t   ex_store_data,
    output logic             redirect,
    output cpu_pkg::word_t   redirect_target
);

    cpu_pkg::word_t     dx_pc;
    cpu_pkg::word_t     dx_a;
    cpu_pkg::word_t     dx_b;
    cpu_pkg::opcode_e   op;
    cpu_pkg::alu_op_e   alu_op;
    logic [4:0]         shamt;
    cpu_pkg::imm_t      imm;
    cpu_pkg::target_t   target;
    cpu_pkg::word_t     imm_ext;
    cpu_pkg::reg_addr_t src_a;
    cpu_pkg::reg_addr_t src_b;
    cpu_pkg::word_t     op_a;
    cpu_pkg::word_t     op_b;
    cpu_pkg::word_t     alu_result;
    logic               hold;

    // --------------------
    // Decode/execute register
    assign hold = fill.start || fill.busy;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_instr <= cpu_pkg::nop_instr;
        end else if (fill.release_fill) begin
            ex_instr <= cpu_pkg::nop_instr;   // Fill retires as a bubble
        end else if (!hold) begin
            ex_instr <= (redirect || stall) ? cpu_pkg::nop_instr : fd_instr;
        end
    end

    // Writeback lands on this same edge, so its value is caught on the way in
    always_ff @(posedge clock) begin
        if (!hold) begin
            dx_pc <= fd_pc;
            dx_a  <= cpu_pkg::produces(fwd_wb_instr, cpu_pkg::src_a_of(fd_instr))
                   ? fwd_wb_value : reg_read_data_a;
            dx_b  <= cpu_pkg::produces(fwd_wb_instr, cpu_pkg::src_b_of(fd_instr))
                   ? fwd_wb_value : reg_read_data_b;
        end
    end

    assign op      = cpu_pkg::opcode_of(ex_instr);
    assign alu_op  = cpu_pkg::alu_op_e'(ex_instr[cpu_pkg::alu_op_lsb +: 5]);
    assign shamt   = ex_instr[cpu_pkg::shamt_lsb +: 5];
    assign imm     = ex_instr[$bits(cpu_pkg::imm_t)-1:0];
    assign target  = ex_instr[$bits(cpu_pkg::target_t)-1:0];
    assign imm_ext = {{15{imm[16]}}, imm};

    // --------------------
    // Forwarding, memory stage wins
    assign src_a = cpu_pkg::src_a_of(ex_instr);
    assign src_b = cpu_pkg::src_b_of(ex_instr);

    assign op_a = cpu_pkg::produces(fwd_mem_instr, src_a) ? fwd_mem_value
                : cpu_pkg::produces(fwd_wb_instr, src_a)  ? fwd_wb_value : dx_a;
    assign op_b = cpu_pkg::produces(fwd_mem_instr, src_b) ? fwd_mem_value
                : cpu_pkg::produces(fwd_wb_instr, src_b)  ? fwd_wb_value : dx_b;

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_sub: alu_result = op_a - op_b;
            cpu_pkg::alu_and: alu_result = op_a & op_b;
            cpu_pkg::alu_or:  alu_result = op_a | op_b;
            cpu_pkg::alu_sll: alu_result = op_a << shamt;
            cpu_pkg::alu_sra: alu_result = $signed(op_a) >>> shamt;
            default:          alu_result = op_a + op_b;
        endcase
    end

    // sw takes its base from rs on port b
    always_comb begin
        case (op)
            cpu_pkg::op_addi, cpu_pkg::op_lw: ex_result = op_a + imm_ext;
            cpu_pkg::op_sw:                   ex_result = op_b + imm_ext;
            default:                          ex_result = alu_result;
        endcase
    end

    assign ex_store_data = op_a;   // rd of a sw

    assign redirect        = (op == cpu_pkg::op_j) || ((op == cpu_pkg::op_bne) && (op_a != op_b));
    assign redirect_target = (op == cpu_pkg::op_j) ? {dx_pc[31:27], target}
                           : dx_pc + 32'd1 + imm_ext;

    // Zero length never starts the sequencer
    assign fill.start  = (op == cpu_pkg::op_fill) && (fill.length != '0) && !fill.busy;
    assign fill.base   = op_a;
    assign fill.length = imm[15:0];

endmodule

`default_nettype wire

/* fill/fill_counter.sv */
// Length must be nonzero at start; last_word is high while one word remains
`default_nettype none

module fill_counter (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  cpu_pkg::fill_count_t  length,
    input  logic                  writing,
    output logic                  last_word
);

    cpu_pkg::fill_count_t remaining;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            remaining <= '0;
        end else if (start) begin
            remaining <= length;
        end else if (writing) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign last_word = (remaining == cpu_pkg::fill_count_t'(1));

endmodule

`default_nettype wire

/* fill/fill_fsm.sv */
// Expects start only while idle; last_word is only looked at in the write state
`default_nettype none

module fill_fsm (
    input  logic        clock,
    input  logic        reset,
    fill_if.sequencer   fill,
    input  logic        last_word
);

    cpu_pkg::fill_state_e state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= cpu_pkg::fill_idle;
        end else begin
            case (state)
                cpu_pkg::fill_idle:    if (fill.start) state <= cpu_pkg::fill_write;
                cpu_pkg::fill_write:   if (last_word) state <= cpu_pkg::fill_release;
                cpu_pkg::fill_release: state <= cpu_pkg::fill_idle;   // One cycle only
                default:               state <= cpu_pkg::fill_idle;
            endcase
        end
    end

    assign fill.busy         = (state != cpu_pkg::fill_idle);
    assign fill.release_fill = (state == cpu_pkg::fill_release);

endmodule

`default_nettype wire

/* fill/fill_store_unit.sv */
// LFSR runs every cycle, so consecutive fill words are consecutive states and never zero
`default_nettype none

module fill_store_unit (
    input  logic     clock,
    input  logic     reset,
    fill_if.store    fill,
    input  logic     writing
);

    cpu_pkg::word_t      base;
    cpu_pkg::word_t      offset;
    cpu_pkg::fill_data_t lfsr;
    logic                feedback;

    always_ff @(posedge clock) begin
        if (fill.start) begin
            base   <= fill.base;
            offset <= '0;
        end else if (writing) begin
            offset <= offset + 32'd1;
        end
    end

    // --------------------
    // Fibonacci LFSR, x^4 + x^3 + 1
    assign feedback = ^(lfsr & cpu_pkg::lfsr_tap_mask);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lfsr <= cpu_pkg::lfsr_seed;
        end else begin
            lfsr <= {lfsr[2:0], feedback};
        end
    end

    assign fill.write_en   = writing;
    assign fill.address    = base + offset;
    assign fill.write_data = cpu_pkg::word_t'(lfsr);   // Zero-extended

endmodule

`default_nettype wire

/* source/front_end.sv */
// PC counts words; redirect, stall and freeze are never raised together by the core
`default_nettype none

module front_end (
    input  logic                clock,
    input  logic                reset,
    output cpu_pkg::word_t      imem_address,
    input  cpu_pkg::instr_t     imem_data,
    input  logic                redirect,
    input  cpu_pkg::word_t      redirect_target,
    input  logic                freeze,
    input  cpu_pkg::instr_t     ex_instr,
    output cpu_pkg::reg_addr_t  reg_read_addr_a,
    output cpu_pkg::reg_addr_t  reg_read_addr_b,
    output cpu_pkg::word_t      fd_pc,
    output cpu_pkg::instr_t     fd_instr,
    output logic                stall
);

    cpu_pkg::word_t     pc;
    cpu_pkg::opcode_e   fd_op;
    logic               uses_a;
    logic               uses_b;
    logic               ex_is_load;
    cpu_pkg::reg_addr_t ex_rd;

    assign imem_address = pc;

    // --------------------
    // PC and fetch/decode register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc       <= '0;
            fd_pc    <= '0;
            fd_instr <= cpu_pkg::nop_instr;
        end else if (redirect) begin
            pc       <= redirect_target;
            fd_instr <= cpu_pkg::nop_instr;   // Squash the wrong-path fetch
        end else if (!(stall || freeze)) begin
            pc       <= pc + 32'd1;
            fd_pc    <= pc;
            fd_instr <= imem_data;
        end
    end

    // --------------------
    // Register read selection
    assign fd_op           = cpu_pkg::opcode_of(fd_instr);
    assign reg_read_addr_a = cpu_pkg::src_a_of(fd_instr);
    assign reg_read_addr_b = cpu_pkg::src_b_of(fd_instr);

    assign uses_a = (fd_op != cpu_pkg::op_j);
    assign uses_b = fd_op inside {cpu_pkg::op_rtype, cpu_pkg::op_bne, cpu_pkg::op_sw};

    // Load data is only ready from writeback, one bubble closes the gap
    assign ex_is_load = (cpu_pkg::opcode_of(ex_instr) == cpu_pkg::op_lw);
    assign ex_rd      = cpu_pkg::rd_of(ex_instr);

    assign stall = ex_is_load && (ex_rd != '0)
                 && ((uses_a && (ex_rd == reg_read_addr_a))
                  || (uses_b && (ex_rd == reg_read_addr_b)));

endmodule

`default_nettype wire

/* source/mem_wb_unit.sv */
// Fill writes take the data memory port; the memory stage only sees bubbles during a fill
`default_nettype none

module mem_wb_unit (
    input  logic                clock,
    input  logic                reset,
    input  cpu_pkg::instr_t     ex_instr,
    input  cpu_pkg::word_t      ex_result,
    input  cpu_pkg::word_t      ex_store_data,
    fill_if.memory              fill,
    output cpu_pkg::word_t      dmem_address,
    output cpu_pkg::word_t      dmem_write_data,
    output logic                dmem_write_enable,
    input  cpu_pkg::word_t      dmem_read_data,
    output cpu_pkg::instr_t     fwd_mem_instr,
    output cpu_pkg::instr_t     fwd_wb_instr,
    output cpu_pkg::word_t      fwd_mem_value,
    output cpu_pkg::word_t      fwd_wb_value,
    output logic                reg_write_enable,
    output cpu_pkg::reg_addr_t  reg_write_addr,
    output cpu_pkg::word_t      reg_write_data
);

    cpu_pkg::instr_t  em_instr;
    cpu_pkg::instr_t  mw_instr;
    cpu_pkg::word_t   em_result;
    cpu_pkg::word_t   em_store_data;
    cpu_pkg::word_t   mw_value;
    cpu_pkg::word_t   mem_value;
    cpu_pkg::opcode_e em_op;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            em_instr <= cpu_pkg::nop_instr;
            mw_instr <= cpu_pkg::nop_instr;
        end else begin
            em_instr <= fill.busy ? cpu_pkg::nop_instr : ex_instr;   // Drain under freeze
            mw_instr <= em_instr;
        end
    end

    always_ff @(posedge clock) begin
        em_result     <= ex_result;
        em_store_data <= ex_store_data;
        mw_value      <= mem_value;
    end

    // --------------------
    // Memory stage
    assign em_op     = cpu_pkg::opcode_of(em_instr);
    assign mem_value = (em_op == cpu_pkg::op_lw) ? dmem_read_data : em_result;

    assign dmem_address      = fill.write_en ? fill.address : em_result;
    assign dmem_write_data   = fill.write_en ? fill.write_data : em_store_data;
    assign dmem_write_enable = fill.write_en || (em_op == cpu_pkg::op_sw);

    assign fwd_mem_instr = em_instr;
    assign fwd_mem_value = mem_value;
    assign fwd_wb_instr  = mw_instr;
    assign fwd_wb_value  = mw_value;

    // --------------------
    // Writeback
    assign reg_write_enable = cpu_pkg::writes_reg(mw_instr);
    assign reg_write_addr   = cpu_pkg::rd_of(mw_instr);
    assign reg_write_data   = mw_value;

endmodule

`default_nettype wire

/* source/processor.sv */
// Memories and register file are external with combinational reads; r0 writes must be ignored
`default_nettype none

module processor (
    input  logic                clock,
    input  logic                reset,
    output cpu_pkg::word_t      imem_address,
    input  cpu_pkg::word_t      imem_data,
    output cpu_pkg::word_t      dmem_address,
    output cpu_pkg::word_t      dmem_write_data,
    output logic                dmem_write_enable,
    input  cpu_pkg::word_t      dmem_read_data,
    output logic                reg_write_enable,
    output cpu_pkg::reg_addr_t  reg_write_addr,
    output cpu_pkg::word_t      reg_write_data,
    output cpu_pkg::reg_addr_t  reg_read_addr_a,
    output cpu_pkg::reg_addr_t  reg_read_addr_b,
    input  cpu_pkg::word_t      reg_read_data_a,
    input  cpu_pkg::word_t      reg_read_data_b
);

    cpu_pkg::word_t  fd_pc;
    cpu_pkg::instr_t fd_instr;
    logic            stall;
    logic            redirect;
    cpu_pkg::word_t  redirect_target;
    cpu_pkg::instr_t ex_instr;
    cpu_pkg::word_t  ex_result;
    cpu_pkg::word_t  ex_store_data;
    cpu_pkg::instr_t fwd_mem_instr;
    cpu_pkg::word_t  fwd_mem_value;
    cpu_pkg::instr_t fwd_wb_instr;
    cpu_pkg::word_t  fwd_wb_value;
    logic            front_freeze;
    logic            fill_writing;
    logic            last_word;

    fill_if fill_bus ();

    // Front end also holds in the start cycle so the fill stays in execute
    assign front_freeze = fill_bus.start || fill_bus.busy;
    assign fill_writing = fill_bus.busy && !fill_bus.release_fill;

    front_end u_front_end (
        .clock           (clock),
        .reset           (reset),
        .imem_address    (imem_address),
        .imem_data       (imem_data),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .freeze          (front_freeze),
        .ex_instr        (ex_instr),
        .reg_read_addr_a (reg_read_addr_a),
        .reg_read_addr_b (reg_read_addr_b),
        .fd_pc           (fd_pc),
        .fd_instr        (fd_instr),
        .stall           (stall)
    );

    execute_stage u_execute_stage (
        .clock           (clock),
        .reset           (reset),
        .fd_pc           (fd_pc),
        .fd_instr        (fd_instr),
        .reg_read_data_a (reg_read_data_a),
        .reg_read_data_b (reg_read_data_b),
        .stall           (stall),
        .fill            (fill_bus.requester),
        .fwd_mem_instr   (fwd_mem_instr),
        .fwd_mem_value   (fwd_mem_value),
        .fwd_wb_instr    (fwd_wb_instr),
        .fwd_wb_value    (fwd_wb_value),
        .ex_instr        (ex_instr),
        .ex_result       (ex_result),
        .ex_store_data   (ex_store_data),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    mem_wb_unit u_mem_wb_unit (
        .clock             (clock),
        .reset             (reset),
        .ex_instr          (ex_instr),
        .ex_result         (ex_result),
        .ex_store_data     (ex_store_data),
        .fill              (fill_bus.memory),
        .dmem_address      (dmem_address),
        .dmem_write_data   (dmem_write_data),
        .dmem_write_enable (dmem_write_enable),
        .dmem_read_data    (dmem_read_data),
        .fwd_mem_instr     (fwd_mem_instr),
        .fwd_wb_instr      (fwd_wb_instr),
        .fwd_mem_value     (fwd_mem_value),
        .fwd_wb_value      (fwd_wb_value),
        .reg_write_enable  (reg_write_enable),
        .reg_write_addr    (reg_write_addr),
        .reg_write_data    (reg_write_data)
    );

    // --------------------
    // Fill block
    fill_fsm u_fill_fsm (
        .clock     (clock),
        .reset     (reset),
        .fill      (fill_bus.sequencer),
        .last_word (last_word)
    );

    fill_counter u_fill_counter (
        .clock     (clock),
        .reset     (reset),
        .start     (fill_bus.start),
        .length    (fill_bus.length),
        .writing   (fill_writing),
        .last_word (last_word)
    );

    fill_store_unit u_fill_store_unit (
        .clock   (clock),
        .reset   (reset),
        .fill    (fill_bus.store),
        .writing (fill_writing)
    );

endmodule

`default_nettype wire

/* verif/processor_props.sv */
// Fill checks follow the internal fill_writing strobe of processor; all sampled on the rising edge
`default_nettype none

module processor_props (
    input logic           clock,
    input logic           reset,
    input logic           dmem_write_enable,
    input logic           reg_write_enable,
    input logic           fill_write,
    input cpu_pkg::word_t dmem_address,
    input cpu_pkg::word_t dmem_write_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // Nothing is written while reset holds
    quiet_in_reset: assert property (@(posedge clock)
        reset |-> (!dmem_write_enable && !reg_write_enable))
        else $error("A write enable was high during reset");

    fill_address_steps: assert property (@(posedge clock) disable iff (reset)
        (fill_write && $past(fill_write)) |-> (dmem_address == $past(dmem_address) + 32'd1))
        else $error("Fill address did not advance by one word");

    fill_data_nonzero: assert property (@(posedge clock) disable iff (reset)
        fill_write |-> (dmem_write_data != '0))   // LFSR never reaches zero
        else $error("Fill wrote a zero data word");

endmodule

bind processor processor_props u_props (
    .clock             (clock),
    .reset             (reset),
    .dmem_write_enable (dmem_write_enable),
    .reg_write_enable  (reg_write_enable),
    .fill_write        (fill_writing),
    .dmem_address      (dmem_address),
    .dmem_write_data   (dmem_write_data)
);

`default_nettype wire

/* verif/processor_tb.sv */
// Models hold 256 instruction and 1024 data words; run data is read from verif/program_vectors.txt
`default_nettype none

module processor_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int vector_depth  = 128;
    localparam int header_words  = 5;
    localparam int settle_cycles = 8;   // Window for stray writes after the last result

    logic                clock;
    logic                reset;
    cpu_pkg::word_t      imem_address;
    cpu_pkg::instr_t     imem_data;
    cpu_pkg::word_t      dmem_address;
    cpu_pkg::word_t      dmem_write_data;
    logic                dmem_write_enable;
    cpu_pkg::word_t      dmem_read_data;
    logic                reg_write_enable;
    cpu_pkg::reg_addr_t  reg_write_addr;
    cpu_pkg::word_t      reg_write_data;
    cpu_pkg::reg_addr_t  reg_read_addr_a;
    cpu_pkg::reg_addr_t  reg_read_addr_b;
    cpu_pkg::word_t      reg_read_data_a;
    cpu_pkg::word_t      reg_read_data_b;

    cpu_pkg::word_t      vectors [0:vector_depth-1];
    cpu_pkg::instr_t     imem [0:255];
    cpu_pkg::word_t      dmem [0:1023];
    cpu_pkg::word_t      regs [0:31];

    int                  program_len;
    int                  init_count;
    int                  store_count;
    int                  write_count;
    int                  fill_total;   // Sum of fill lengths
    int                  init_base;
    int                  store_base;
    int                  write_base;
    int                  stores_seen;
    int                  writes_seen;
    int                  cycle_count;
    int                  cycle_limit;
    int                  seed = 32'h83555d89;   // No random stimulus in this program
    logic                first_fetch_checked;
    cpu_pkg::fill_data_t last_fill;

    processor u_dut (
        .clock             (clock),
        .reset             (reset),
        .imem_address      (imem_address),
        .imem_data         (imem_data),
        .dmem_address      (dmem_address),
        .dmem_write_data   (dmem_write_data),
        .dmem_write_enable (dmem_write_enable),
        .dmem_read_data    (dmem_read_data),
        .reg_write_enable  (reg_write_enable),
        .reg_write_addr    (reg_write_addr),
        .reg_write_data    (reg_write_data),
        .reg_read_addr_a   (reg_read_addr_a),
        .reg_read_addr_b   (reg_read_addr_b),
        .reg_read_data_a   (reg_read_data_a),
        .reg_read_data_b   (reg_read_data_b)
    );

    // --------------------
    // Memory and register file models
    assign imem_data       = imem[imem_address[7:0]];
    assign dmem_read_data  = dmem[dmem_address[9:0]];
    assign reg_read_data_a = regs[reg_read_addr_a];
    assign reg_read_data_b = regs[reg_read_addr_b];

    always @(posedge clock) begin
        if (dmem_write_enable === 1'b1) begin
            dmem[dmem_address[9:0]] <= dmem_write_data;
        end
        if ((reg_write_enable === 1'b1) && (reg_write_addr != '0)) begin
            regs[reg_write_addr] <= reg_write_data;   // r0 stays zero
        end
    end

    initial begin
        clock = 1'b0;
        forever begin
            #50;
            clock = ~clock;
        end
    end

    // --------------------
    // Helpers
    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, cpu_pkg::word_t expected, cpu_pkg::word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_reg_addr(string name, cpu_pkg::reg_addr_t expected,
                                  cpu_pkg::reg_addr_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_fill_data(string name, cpu_pkg::fill_data_t expected,
                                   cpu_pkg::fill_data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // x^4 + x^3 + 1, shifting toward the MSB with the top two bits as feedback
    function automatic cpu_pkg::fill_data_t lfsr_successor(cpu_pkg::fill_data_t state);
        return {state[2:0], state[3] ^ state[2]};
    endfunction

    task automatic load_vectors();
        for (int i = 0; i < vector_depth; i++) vectors[i] = '0;
        $readmemh("verif/program_vectors.txt", vectors);
        program_len = vectors[0];
        init_count  = vectors[1];
        store_count = vectors[2];
        write_count = vectors[3];
        fill_total  = vectors[4];
        init_base   = header_words + program_len;
        store_base  = init_base + 2 * init_count;
        write_base  = store_base + 3 * store_count;
        cycle_limit = 4 * program_len + fill_total + 20;
        for (int i = 0; i < 256; i++) imem[i] = '0;   // Past the program only bubbles
        for (int i = 0; i < 1024; i++) dmem[i] = 32'hd000_0000 + i;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < program_len; i++) imem[i] = vectors[header_words + i];
        for (int i = 0; i < init_count; i++) begin
            regs[vectors[init_base + 2 * i][4:0]] = vectors[init_base + 2 * i + 1];
        end
    endtask

    task automatic check_store();
        int             idx;
        string          name;
        cpu_pkg::word_t kind;
        idx  = store_base + 3 * stores_seen;
        kind = vectors[idx];
        name = $sformatf("store %0d", stores_seen);
        if (stores_seen >= store_count) begin
            abort_run($sformatf("Unexpected store to address %h after the last expected one",
                                dmem_address));
        end else begin
            check_word({name, " address"}, vectors[idx + 1], dmem_address);
            if (kind == 0) begin
                check_word({name, " data"}, vectors[idx + 2], dmem_write_data);
            end else begin
                check_word({name, " upper bits"}, '0, {dmem_write_data[31:4], 4'h0});
                if (kind == 1) begin
                    if (dmem_write_data[3:0] == '0) begin
                        abort_run($sformatf("First fill word of %s is zero", name));
                    end
                end else begin
                    check_fill_data({name, " fill sequence"}, lfsr_successor(last_fill),
                                    dmem_write_data[3:0]);
                end
                last_fill = dmem_write_data[3:0];
            end
            stores_seen++;
        end
    endtask

    task automatic check_reg_write();
        int    idx;
        string name;
        idx  = write_base + 2 * writes_seen;
        name = $sformatf("register write %0d", writes_seen);
        if (writes_seen >= write_count) begin
            abort_run($sformatf("Unexpected write to register %0d after the last expected one",
                                reg_write_addr));
        end else begin
            check_reg_addr({name, " address"}, cpu_pkg::reg_addr_t'(vectors[idx]), reg_write_addr);
            check_word({name, " data"}, vectors[idx + 1], reg_write_data);
            writes_seen++;
        end
    endtask

    // --------------------
    // Result monitor, mid-cycle when outputs are settled
    always @(negedge clock) begin
        if (cycle_count > 0) begin
            if (reset) begin
                check_word("reset fetch address", '0, imem_address);
                if ((dmem_write_enable !== 1'b0) || (reg_write_enable !== 1'b0)) begin
                    abort_run("A write enable was not low during reset");
                end
            end else begin
                if (!first_fetch_checked) begin
                    check_word("first fetch address", '0, imem_address);
                    first_fetch_checked = 1'b1;
                end
                if (dmem_write_enable) check_store();
                if (reg_write_enable) check_reg_write();
            end
        end
    end

    initial begin
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                abort_run($sformatf("Timeout, the program did not finish within %0d cycles",
                                    cycle_limit));
            end
        end
    end

    initial begin
        reset               = 1'b1;
        first_fetch_checked = 1'b0;
        stores_seen         = 0;
        writes_seen         = 0;
        last_fill           = '0;
        load_vectors();
        if (program_len == 0) begin
            abort_run("The vector file is missing or holds no program");
        end else begin
            repeat (2) @(posedge clock);
            #10;
            reset = 1'b0;
            wait ((stores_seen == store_count) && (writes_seen == write_count));
            repeat (settle_cycles) @(posedge clock);
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verif/program_vectors.txt */
// Header (hex): program words, register inits, stores, register writes, sum of fill lengths
// Then program words, inits as reg data, stores as kind address data, writes as reg data
18 04 08 0c 05
// Program, one instruction per word address
01422000  // 0  add  r5, r1, r2
018a1004  // 1  sub  r6, r5, r1
01cc0110  // 2  sll  r7, r6, 2
020e100c  // 3  or   r8, r7, r1
2a51fffc  // 4  addi r9, r8, -4
02841004  // 5  sub  r10, r2, r1
02d40094  // 6  sra  r11, r10, 1
3a460004  // 7  sw   r9, 4(r3)
43060004  // 8  lw   r12, 4(r3)
03581000  // 9  add  r13, r12, r1
13420002  // 10 bne  r13, r1, +2 (taken)
2b80006f  // 11 addi r14, r0, 111 (skipped)
2bc000de  // 12 addi r15, r0, 222 (skipped)
08000010  // 13 j    16
2b80014d  // 14 addi r14, r0, 333 (skipped)
2bc001bc  // 15 addi r15, r0, 444 (skipped)
2c000011  // 16 addi r16, r0, 0x11
3c060000  // 17 sw   r16, 0(r3)
48080005  // 18 fill r4, 5
2c600001  // 19 addi r17, r16, 1
48080000  // 20 fill r4, 0
3c460008  // 21 sw   r17, 8(r3)
10420002  // 22 bne  r1, r1, +2 (not taken)
2ca20100  // 23 addi r18, r17, 0x100
// Initial registers
01 00000005
02 00000003
03 00000100
04 00000200
// Stores: kind 0 exact data, 1 first fill word, 2 following fill word
0 00000104 00000009
0 00000100 00000011
1 00000200 00000000
2 00000201 00000000
2 00000202 00000000
2 00000203 00000000
2 00000204 00000000
0 00000108 00000012
// Register writes in program order
05 00000008
06 00000003
07 0000000c
08 0000000d
09 00000009
0a fffffffe
0b ffffffff
0c 00000009
0d 0000000e
10 00000011
11 00000012
12 00000112
